// File: aes_ctrl.f
+incdir+src
src/aes_ctrl_pkg.sv
src/aes_round_counter.sv
src/aes_sequencer.sv
src/aes_ctrl_decoder.sv
src/aes_control_unit.sv
dv/aes_ctrl_checker.sv
dv/tb_aes_control_unit.sv

// File: Makefile
# Verilator build, run and lint of the AES control unit

TOP := tb_aes_control_unit
LOG := sim.log

.PHONY: all lint clean

all:
	verilator --binary --timing -f aes_ctrl.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "STATUS: PASS" $(LOG)

lint:
	verilator --lint-only -Wall +incdir+src \
		src/aes_ctrl_pkg.sv src/aes_round_counter.sv src/aes_sequencer.sv \
		src/aes_ctrl_decoder.sv src/aes_control_unit.sv \
		--top-module aes_control_unit

clean:
	rm -rf obj_dir $(LOG)

// File: dv/tb_aes_control_unit.sv
/*
 * Testbench of the AES control unit
 * Clock, reset, random operations with aborts, checker, timeout
 */

`timescale 1ns/1ps
`default_nettype none

module tb_aes_control_unit;
	import aes_ctrl_pkg::*;

	localparam int NUM_OPS      = 200;
	localparam int RESET_CYCLES = 5;
	// Longest operation, decrypt with derivation, plus its gap stays under 160
	localparam int TIMEOUT_CYCLES = NUM_OPS * 160;

	logic           clk = 1'b0;
	logic           rst_n;
	op_mode_e       operation_mode;
	aes_mode_e      aes_mode;
	logic           start;
	logic           disable_core;
	datapath_ctrl_t ctrl;
	round_t         round;
	logic           end_comp;
	logic           key_gen;
	logic           mode_ctr;
	logic           mode_cbc;
	logic           last_round;
	logic           encrypt_decrypt;
	int             check_count;
	int             error_count;
	int             cycle_count = 0;
	int             ops_done = 0;
	int             ops_aborted = 0;
	logic [31:0]    rng_state;

	// 8 ns period
	always #4 clk = ~clk;

	aes_control_unit uut (
		.clk             (clk),
		.rst_n           (rst_n),
		.operation_mode  (operation_mode),
		.aes_mode        (aes_mode),
		.start           (start),
		.disable_core    (disable_core),
		.ctrl            (ctrl),
		.round           (round),
		.end_comp        (end_comp),
		.key_gen         (key_gen),
		.mode_ctr        (mode_ctr),
		.mode_cbc        (mode_cbc),
		.last_round      (last_round),
		.encrypt_decrypt (encrypt_decrypt)
	);

	aes_ctrl_checker u_checker (
		.clk             (clk),
		.rst_n           (rst_n),
		.operation_mode  (operation_mode),
		.aes_mode        (aes_mode),
		.start           (start),
		.disable_core    (disable_core),
		.ctrl            (ctrl),
		.round           (round),
		.end_comp        (end_comp),
		.key_gen         (key_gen),
		.mode_ctr        (mode_ctr),
		.mode_cbc        (mode_cbc),
		.last_round      (last_round),
		.encrypt_decrypt (encrypt_decrypt),
		.check_count     (check_count),
		.error_count     (error_count)
	);

	// ====================
	// Helpers
	// ====================

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic draw_random(output logic [31:0] value);
		rng_state = xorshift32(rng_state);
		value     = rng_state;
	endtask

	task automatic report_counts();
		$display("Operations: %0d done, %0d aborted; checks: %0d, errors: %0d",
		         ops_done, ops_aborted, check_count, error_count);
	endtask

	// One operation with random modes, gap and maybe an abort
	task automatic run_operation();
		logic [31:0] r;
		int          gap;
		int          abort_at;
		int          waited;
		logic        do_abort;
		logic        done;
		draw_random(r);
		gap      = int'(r[2:0]);
		// About one in sixteen
		do_abort = (r[7:4] == 4'd0);
		abort_at = int'(r[13:8]) + 1;
		repeat (gap) @(negedge clk);

		draw_random(r);
		operation_mode = op_mode_e'(r[1:0]);
		aes_mode       = aes_mode_e'(2'(r % 32'd3));
		start          = 1'b1;
		@(negedge clk);
		start = 1'b0;

		waited = 1;
		done   = 1'b0;
		while (!done)
		begin
			if (end_comp === 1'b1)
			begin
				ops_done++;
				done = 1'b1;
				// Ready falls back to idle
				@(negedge clk);
			end
			else if (do_abort && (waited == abort_at))
			begin
				disable_core = 1'b1;
				@(negedge clk);
				disable_core = 1'b0;
				ops_aborted++;
				done = 1'b1;
			end
			else
			begin
				@(negedge clk);
				waited++;
			end
		end
	endtask

	// ====================
	// Stimulus
	// ====================

	initial
	begin
		rng_state      = 32'hc7b6_f856;
		operation_mode = opm_encryption;
		aes_mode       = aes_ecb;
		start          = 1'b0;
		disable_core   = 1'b0;
		rst_n          = 1'b0;
		repeat (RESET_CYCLES) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);

		for (int i = 0; i < NUM_OPS; i++)
			run_operation();

		repeat (2) @(negedge clk);
		report_counts();
		if ((error_count == 0) && (check_count > 0) && (ops_done > 0))
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

	// Run limit
	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES)
		begin
			$display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			report_counts();
			$display("STATUS: FAIL");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: dv/aes_ctrl_checker.sv
/*
 * Reference model and output checker of the AES control unit
 * Phase and round model, expected control word, per-field compare
 */

`timescale 1ns/1ps
`default_nettype none

`include "aes_ctrl_params.svh"

module aes_ctrl_checker
(
	input  wire logic                    clk,
	input  wire logic                    rst_n,
	input  aes_ctrl_pkg::op_mode_e       operation_mode,
	input  aes_ctrl_pkg::aes_mode_e      aes_mode,
	input  wire logic                    start,
	input  wire logic                    disable_core,
	input  aes_ctrl_pkg::datapath_ctrl_t ctrl,
	input  aes_ctrl_pkg::round_t         round,
	input  wire logic                    end_comp,
	input  wire logic                    key_gen,
	input  wire logic                    mode_ctr,
	input  wire logic                    mode_cbc,
	input  wire logic                    last_round,
	input  wire logic                    encrypt_decrypt,
	output int                           check_count,
	output int                           error_count
);
	import aes_ctrl_pkg::*;

	localparam int NUM_ROUNDS = `AES_CTRL_NUM_ROUNDS;
	localparam int NUM_COLS   = `AES_CTRL_NUM_COLS;
	// Round 0 columns, round_key, round 1 columns, nine more rounds with nop, ready
	localparam int ENC_LATENCY = NUM_COLS + 1 + NUM_COLS + (NUM_ROUNDS - 1) * (NUM_COLS + 2) + 1;

	typedef enum logic [2:0] {
		ph_idle,
		ph_round0,
		ph_round_key,
		ph_nop,
		ph_round,
		ph_gen_key,
		ph_ready
	} phase_e;

	// Model state
	phase_e m_phase;
	int     m_col;
	int     m_round;
	int     since_start;
	logic   timing_on;

	// Mode view and expectations
	op_mode_e       eff_op;
	logic           is_ctr;
	logic           is_cbc;
	logic           key_only;
	logic           key_dir;
	logic           fwd;
	logic           m_first;
	logic           m_last;
	logic           walk_end;
	datapath_ctrl_t exp_ctrl;

	function automatic lane_mask_t one_lane(input int idx);
		return lane_mask_t'(1 << idx);
	endfunction

	// ====================
	// Mode decode
	// ====================

	always_comb
	begin
		is_ctr   = (aes_mode == aes_ctr);
		is_cbc   = (aes_mode == aes_cbc);
		// CTR always encrypts
		eff_op   = is_ctr ? opm_encryption : operation_mode;
		key_only = (eff_op == opm_key_derivation);
		// Key expansion steps count as forward
		key_dir  = (eff_op == opm_encryption) || key_only || (m_phase == ph_gen_key);
		fwd      = key_dir || is_ctr;
		m_first  = (m_round == 0);
		m_last   = (m_round == NUM_ROUNDS) || (m_round == NUM_ROUNDS + 1);
	end

	// ====================
	// Expected control word
	// ====================

	always_comb
	begin
		exp_ctrl         = '0;
		exp_ctrl.col_sel = col_input;
		// Forward walks end on col3, backward on col0
		walk_end = fwd ? (m_col == NUM_COLS - 1) : (m_col == 0);
		case (m_phase)
			ph_round0:
			begin
				exp_ctrl.sbox_sel      = sbox_sel_e'(3'(m_col));
				exp_ctrl.key_out_sel   = key_out_sel_t'(m_col);
				exp_ctrl.bypass_rk     = 1'b1;
				exp_ctrl.bypass_key_en = 1'b1;
				exp_ctrl.col_sel       = walk_end ? col_shift_rows : col_add_rk_out;
				exp_ctrl.col_en        = walk_end ? '1 : one_lane(m_col);
				if (!fwd && (m_col > 0))
				begin
					exp_ctrl.key_sel = 1'b1;
					exp_ctrl.key_en  = one_lane(m_col);
				end
			end
			ph_round:
			begin
				exp_ctrl.sbox_sel    = sbox_sel_e'(3'(m_col));
				exp_ctrl.key_out_sel = key_out_sel_t'(m_col);
				exp_ctrl.key_sel     = 1'b1;
				exp_ctrl.rk_sel      = m_last ? rk_mixcol_in : rk_mixcol_out;
				if (fwd && (m_col < NUM_COLS - 1))
					exp_ctrl.key_en = one_lane(m_col + 1);
				else if (!fwd && (m_col > 0))
					exp_ctrl.key_en = one_lane(m_col);
				// Last round of CBC decrypt or CTR takes the input bus
				if (m_last && ((is_cbc && !fwd) || is_ctr))
					exp_ctrl.col_sel = col_input;
				else if (walk_end && !m_last)
					exp_ctrl.col_sel = col_shift_rows;
				else
					exp_ctrl.col_sel = col_add_rk_out;
				exp_ctrl.col_en = (walk_end && !m_last) ? '1 : one_lane(m_col);
				if (is_ctr && m_last && (m_col == NUM_COLS - 1))
				begin
					exp_ctrl.iv_cnt_en  = 1'b1;
					exp_ctrl.iv_cnt_sel = 1'b1;
				end
			end
			ph_round_key:
			begin
				exp_ctrl.sbox_sel = sbox_g_function;
				exp_ctrl.key_sel  = 1'b1;
				exp_ctrl.key_en   = one_lane(0);
			end
			ph_gen_key:
			begin
				if (m_col == 0)
					exp_ctrl.sbox_sel = sbox_g_function;
				else
				begin
					exp_ctrl.key_sel       = 1'b1;
					exp_ctrl.bypass_key_en = 1'b1;
					// Step 1 writes words 0 and 1 at once
					exp_ctrl.key_en = (m_col == 1) ? (one_lane(0) | one_lane(1)) : one_lane(m_col);
				end
			end
			ph_ready:
				exp_ctrl.key_derivation_en = key_only;
			default:
				exp_ctrl.key_derivation_en = 1'b0;
		endcase
	end

	// ====================
	// Compare
	// ====================

	task automatic check_value(input string name, input logic [31:0] got,
	                           input logic [31:0] expected);
		check_count++;
		if (got !== expected)
		begin
			error_count++;
			$display("Error %0t: %s is %0h, expected %0h", $time, name, got, expected);
		end
	endtask

	task automatic compare_outputs();
		check_value("ctrl.sbox_sel", 32'(ctrl.sbox_sel), 32'(exp_ctrl.sbox_sel));
		check_value("ctrl.rk_sel", 32'(ctrl.rk_sel), 32'(exp_ctrl.rk_sel));
		check_value("ctrl.key_out_sel", 32'(ctrl.key_out_sel), 32'(exp_ctrl.key_out_sel));
		check_value("ctrl.col_sel", 32'(ctrl.col_sel), 32'(exp_ctrl.col_sel));
		check_value("ctrl.key_en", 32'(ctrl.key_en), 32'(exp_ctrl.key_en));
		check_value("ctrl.col_en", 32'(ctrl.col_en), 32'(exp_ctrl.col_en));
		check_value("ctrl.bypass_rk", 32'(ctrl.bypass_rk), 32'(exp_ctrl.bypass_rk));
		check_value("ctrl.bypass_key_en", 32'(ctrl.bypass_key_en),
		            32'(exp_ctrl.bypass_key_en));
		check_value("ctrl.key_sel", 32'(ctrl.key_sel), 32'(exp_ctrl.key_sel));
		check_value("ctrl.iv_cnt_en", 32'(ctrl.iv_cnt_en), 32'(exp_ctrl.iv_cnt_en));
		check_value("ctrl.iv_cnt_sel", 32'(ctrl.iv_cnt_sel), 32'(exp_ctrl.iv_cnt_sel));
		check_value("ctrl.key_derivation_en", 32'(ctrl.key_derivation_en),
		            32'(exp_ctrl.key_derivation_en));
		check_value("round", 32'(round), 32'(m_round));
		check_value("end_comp", 32'(end_comp), 32'(m_phase == ph_ready));
		check_value("key_gen", 32'(key_gen), 32'(m_phase == ph_round_key));
		check_value("mode_ctr", 32'(mode_ctr), 32'(is_ctr));
		check_value("mode_cbc", 32'(mode_cbc), 32'(is_cbc));
		check_value("last_round", 32'(last_round), 32'(m_last));
		check_value("encrypt_decrypt", 32'(encrypt_decrypt), 32'(key_dir));
		// Forward operations finish at a fixed distance from start
		if ((end_comp === 1'b1) && timing_on && (since_start != ENC_LATENCY))
		begin
			error_count++;
			$display("Error %0t: end_comp after %0d cycles, expected %0d",
			         $time, since_start, ENC_LATENCY);
		end
	endtask

	// ====================
	// Model update
	// ====================

	task automatic advance_model();
		phase_e np;
		int     nc;
		int     nr;
		np = m_phase;
		nc = m_col;
		nr = m_round;
		case (m_phase)
			ph_idle:
			begin
				if (start)
				begin
					np = (eff_op == opm_encryption || eff_op == opm_decryption) ?
					     ph_round0 : ph_gen_key;
					nc = (eff_op == opm_decryption) ? NUM_COLS - 1 : 0;
				end
			end
			ph_round0, ph_round:
			begin
				if (fwd && (m_col < NUM_COLS - 1))
					nc = m_col + 1;
				else if (!fwd && (m_col > 0))
					nc = m_col - 1;
				else if ((m_phase == ph_round) && fwd && m_last)
					np = ph_ready;
				else
					np = ph_round_key;
			end
			ph_round_key:
			begin
				if (m_first)
				begin
					np = ph_round;
					nc = fwd ? 0 : NUM_COLS - 1;
				end
				else
					np = m_last ? ph_ready : ph_nop;
			end
			ph_nop:
			begin
				np = ph_round;
				nc = fwd ? 0 : NUM_COLS - 1;
			end
			ph_gen_key:
			begin
				if (m_col < NUM_COLS - 1)
					nc = m_col + 1;
				else if (!m_last)
					nc = 0;
				else if (key_only)
					np = ph_ready;
				else
				begin
					// Derived key feeds a decryption
					np = ph_round0;
					nc = NUM_COLS - 1;
				end
			end
			default:
				np = ph_idle;
		endcase

		// Round index
		if ((m_phase == ph_idle) ||
		    ((m_phase == ph_gen_key) && (m_col == NUM_COLS - 1) && m_last))
			nr = 0;
		else if ((m_phase == ph_round_key) || ((m_phase == ph_gen_key) && (m_col == 0)))
			nr = m_round + 1;

		if (disable_core)
			np = ph_idle;

		m_phase <= np;
		m_col   <= nc;
		m_round <= nr;

		// Latency tracking of forward operations
		if (disable_core)
			timing_on <= 1'b0;
		else if ((m_phase == ph_idle) && start)
		begin
			timing_on   <= (eff_op == opm_encryption);
			// First round-0 column is cycle 1
			since_start <= 1;
		end
		else if (m_phase == ph_ready)
			timing_on <= 1'b0;
		else
			since_start <= since_start + 1;
	endtask

	always @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			m_phase     <= ph_idle;
			m_col       <= 0;
			m_round     <= 0;
			since_start <= 0;
			timing_on   <= 1'b0;
			check_count = 0;
			error_count = 0;
		end
		else
		begin
			// Outputs still show the cycle before this edge
			compare_outputs();
			advance_model();
		end
	end

endmodule

`default_nettype wire

// File: src/aes_control_unit.sv
/*
 * Top of the AES-128 round control unit
 * Sequencer, round counter and output decode
 */

`timescale 1ns/1ps
`default_nettype none

module aes_control_unit
(
	input  wire logic                    clk,
	input  wire logic                    rst_n,
	input  aes_ctrl_pkg::op_mode_e       operation_mode,
	input  aes_ctrl_pkg::aes_mode_e      aes_mode,
	input  wire logic                    start,
	input  wire logic                    disable_core,
	output aes_ctrl_pkg::datapath_ctrl_t ctrl,
	output aes_ctrl_pkg::round_t         round,
	output logic                         end_comp,
	output logic                         key_gen,
	output logic                         mode_ctr,
	output logic                         mode_cbc,
	output logic                         last_round,
	output logic                         encrypt_decrypt
);
	import aes_ctrl_pkg::*;

	ctrl_state_e state;
	mode_flags_t flags;
	logic        round_clear;
	logic        round_advance;
	logic        first_round;

	// Sequence control
	aes_sequencer u_sequencer (
		.clk            (clk),
		.rst_n          (rst_n),
		.operation_mode (operation_mode),
		.aes_mode       (aes_mode),
		.start          (start),
		.disable_core   (disable_core),
		.first_round    (first_round),
		.last_round     (last_round),
		.state          (state),
		.flags          (flags),
		.round_clear    (round_clear),
		.round_advance  (round_advance)
	);

	aes_round_counter u_round_counter (
		.clk           (clk),
		.rst_n         (rst_n),
		.round_clear   (round_clear),
		.round_advance (round_advance),
		.round         (round),
		.first_round   (first_round),
		.last_round    (last_round)
	);

	aes_ctrl_decoder u_decoder (
		.state      (state),
		.flags      (flags),
		.last_round (last_round),
		.ctrl       (ctrl)
	);

	// Status straight from the state and mode flags
	assign end_comp        = (state == st_ready);
	assign key_gen         = (state == st_round_key);
	assign mode_ctr        = flags.mode_ctr;
	assign mode_cbc        = flags.mode_cbc;
	assign encrypt_decrypt = flags.encrypt_decrypt;

endmodule

`default_nettype wire

// File: src/aes_ctrl_decoder.sv
/*
 * Output decode of the AES control unit
 * Per-state select and enable lines of the datapath
 */

`timescale 1ns/1ps
`default_nettype none

module aes_ctrl_decoder
(
	input  aes_ctrl_pkg::ctrl_state_e    state,
	input  aes_ctrl_pkg::mode_flags_t    flags,
	input  wire logic                    last_round,
	output aes_ctrl_pkg::datapath_ctrl_t ctrl
);
	import aes_ctrl_pkg::*;

	localparam logic KEY_HOST = 1'b0;
	localparam logic KEY_OUT  = 1'b1;
	localparam logic IV_BUS   = 1'b0;
	localparam logic IV_CNT   = 1'b1;

	localparam lane_mask_t LANE_NONE = '0;
	localparam lane_mask_t LANE_ALL  = '1;

	key_out_sel_t col_idx;
	logic         in_round0;
	logic         in_round;
	logic         final_col;
	logic         reroute;

	// One-hot lane of a column
	function automatic lane_mask_t lane(input key_out_sel_t idx);
		lane = lane_mask_t'(1) << idx;
	endfunction

	// ====================
	// Column tracking
	// ====================

	always_comb
	begin
		col_idx = 2'd0;
		case (state)
			st_round0_col1, st_round_col1: col_idx = 2'd1;
			st_round0_col2, st_round_col2: col_idx = 2'd2;
			st_round0_col3, st_round_col3: col_idx = 2'd3;
			default:                       col_idx = 2'd0;
		endcase
	end

	assign in_round0 = (state inside {st_round0_col0, st_round0_col1,
	                                  st_round0_col2, st_round0_col3});
	assign in_round  = (state inside {st_round_col0, st_round_col1,
	                                  st_round_col2, st_round_col3});

	// Last column of the walk, where the whole state loads shifted
	assign final_col = flags.enc_dec ? (col_idx == 2'd3) : (col_idx == 2'd0);

	// Last round of CBC decryption or CTR feeds the columns from the input
	assign reroute = last_round && ((flags.mode_cbc && !flags.enc_dec) || flags.mode_ctr);

	// ====================
	// Control word
	// ====================

	always_comb
	begin
		// Idle values
		ctrl.sbox_sel          = sbox_col0;
		ctrl.rk_sel            = rk_column;
		ctrl.key_out_sel       = 2'd0;
		ctrl.col_sel           = col_input;
		ctrl.key_en            = LANE_NONE;
		ctrl.col_en            = LANE_NONE;
		ctrl.bypass_rk         = 1'b0;
		ctrl.bypass_key_en     = 1'b0;
		ctrl.key_sel           = KEY_HOST;
		ctrl.iv_cnt_en         = 1'b0;
		ctrl.iv_cnt_sel        = IV_BUS;
		ctrl.key_derivation_en = 1'b0;

		if (in_round0)
		begin
			// Initial AddRoundKey straight from the key registers
			ctrl.sbox_sel      = sbox_sel_e'({1'b0, col_idx});
			ctrl.key_out_sel   = col_idx;
			ctrl.bypass_rk     = 1'b1;
			ctrl.bypass_key_en = 1'b1;
			ctrl.col_sel       = final_col ? col_shift_rows : col_add_rk_out;
			ctrl.col_en        = final_col ? LANE_ALL : lane(col_idx);
			// Decryption rewinds key words 3 to 1 as it goes
			if (!flags.enc_dec && (col_idx != 2'd0))
			begin
				ctrl.key_sel = KEY_OUT;
				ctrl.key_en  = lane(col_idx);
			end
		end
		else if (in_round)
		begin
			ctrl.sbox_sel    = sbox_sel_e'({1'b0, col_idx});
			ctrl.key_out_sel = col_idx;
			ctrl.key_sel     = KEY_OUT;
			// No MixColumns in the last round
			ctrl.rk_sel      = last_round ? rk_mixcol_in : rk_mixcol_out;

			// Key word update runs one ahead forward, in place backward
			if (flags.enc_dec)
			begin
				if (col_idx != 2'd3)
					ctrl.key_en = lane(key_out_sel_t'(col_idx + 2'd1));
			end
			else if (col_idx != 2'd0)
				ctrl.key_en = lane(col_idx);

			if (reroute)
				ctrl.col_sel = col_input;
			else if (final_col && !last_round)
				ctrl.col_sel = col_shift_rows;
			else
				ctrl.col_sel = col_add_rk_out;

			ctrl.col_en = (final_col && !last_round) ? LANE_ALL : lane(col_idx);

			// Counter IV steps once the block is done
			if ((col_idx == 2'd3) && flags.mode_ctr && last_round)
			begin
				ctrl.iv_cnt_en  = 1'b1;
				ctrl.iv_cnt_sel = IV_CNT;
			end
		end
		else
		begin
			case (state)
				st_round_key:
				begin
					// g-function on the last key word into word 0
					ctrl.sbox_sel = sbox_g_function;
					ctrl.key_sel  = KEY_OUT;
					ctrl.key_en   = lane(2'd0);
				end
				st_gen_key0:
					ctrl.sbox_sel = sbox_g_function;
				st_gen_key1:
				begin
					// Words 0 and 1 together
					ctrl.key_en        = lane(2'd0) | lane(2'd1);
					ctrl.key_sel       = KEY_OUT;
					ctrl.bypass_key_en = 1'b1;
				end
				st_gen_key2, st_gen_key3:
				begin
					ctrl.key_en        = (state == st_gen_key2) ? lane(2'd2) : lane(2'd3);
					ctrl.key_sel       = KEY_OUT;
					ctrl.bypass_key_en = 1'b1;
				end
				st_ready:
					ctrl.key_derivation_en = flags.op_key_derivation;
				default:
					ctrl.key_derivation_en = 1'b0;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: src/aes_sequencer.sv
/*
 * Column and round sequencer of the AES control unit
 * Mode decode, state register, next-state logic, counter control
 */

`timescale 1ns/1ps
`default_nettype none

module aes_sequencer
(
	input  wire logic                 clk,
	input  wire logic                 rst_n,
	input  aes_ctrl_pkg::op_mode_e    operation_mode,
	input  aes_ctrl_pkg::aes_mode_e   aes_mode,
	input  wire logic                 start,
	input  wire logic                 disable_core,
	input  wire logic                 first_round,
	input  wire logic                 last_round,
	output aes_ctrl_pkg::ctrl_state_e state,
	output aes_ctrl_pkg::mode_flags_t flags,
	output logic                      round_clear,
	output logic                      round_advance
);
	import aes_ctrl_pkg::*;

	op_mode_e    op_mode;
	ctrl_state_e next_state;
	logic        is_ctr;
	logic        in_gen_key;
	logic        encrypt_dir;
	logic        enc_dec;

	// ====================
	// Mode decode
	// ====================

	// CTR only ever uses the forward cipher
	assign is_ctr  = (aes_mode == aes_ctr);
	assign op_mode = is_ctr ? opm_encryption : operation_mode;

	assign in_gen_key = (state inside {st_gen_key0, st_gen_key1, st_gen_key2, st_gen_key3});

	// Key expansion always runs forward
	assign encrypt_dir = (op_mode == opm_encryption) || (op_mode == opm_key_derivation) ||
	                     in_gen_key;
	assign enc_dec     = encrypt_dir | is_ctr;

	assign flags = '{
		encrypt_decrypt:   encrypt_dir,
		enc_dec:           enc_dec,
		mode_ctr:          is_ctr,
		mode_cbc:          (aes_mode == aes_cbc),
		op_key_derivation: (op_mode == opm_key_derivation)
	};

	// ====================
	// State register
	// ====================

	// Abort lands in idle from anywhere
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			state <= st_idle;
		else if (disable_core)
			state <= st_idle;
		else
			state <= next_state;
	end

	// ====================
	// Next state
	// ====================

	// Encryption walks col0 up to col3, decryption col3 down to col0
	always_comb
	begin
		next_state = state;
		case (state)
			st_idle:
			begin
				// Start only counts here
				if (start)
				begin
					case (op_mode)
						opm_encryption:     next_state = st_round0_col0;
						opm_decryption:     next_state = st_round0_col3;
						default:            next_state = st_gen_key0;
					endcase
				end
			end
			st_round0_col0: next_state = enc_dec ? st_round0_col1 : st_round_key;
			st_round0_col1: next_state = enc_dec ? st_round0_col2 : st_round0_col0;
			st_round0_col2: next_state = enc_dec ? st_round0_col3 : st_round0_col1;
			st_round0_col3: next_state = enc_dec ? st_round_key   : st_round0_col2;
			st_round_key:
			begin
				// Round 1 has no idle slot ahead of its columns
				if (first_round)
					next_state = enc_dec ? st_round_col0 : st_round_col3;
				else
					next_state = last_round ? st_ready : st_nop;
			end
			st_nop:         next_state = enc_dec ? st_round_col0 : st_round_col3;
			st_round_col0:  next_state = enc_dec ? st_round_col1 : st_round_key;
			st_round_col1:  next_state = enc_dec ? st_round_col2 : st_round_col0;
			st_round_col2:  next_state = enc_dec ? st_round_col3 : st_round_col1;
			st_round_col3:
			begin
				if (enc_dec)
					next_state = last_round ? st_ready : st_round_key;
				else
					next_state = st_round_col2;
			end
			st_gen_key0:    next_state = st_gen_key1;
			st_gen_key1:    next_state = st_gen_key2;
			st_gen_key2:    next_state = st_gen_key3;
			st_gen_key3:
			begin
				// Final key schedule reached, stop or decrypt with it
				if (last_round)
					next_state = flags.op_key_derivation ? st_ready : st_round0_col3;
				else
					next_state = st_gen_key0;
			end
			st_ready:       next_state = st_idle;
			default:        next_state = st_idle;
		endcase
	end

	// Counter control
	assign round_clear   = (state == st_idle) || ((state == st_gen_key3) && last_round);
	assign round_advance = (state == st_round_key) || (state == st_gen_key0);

endmodule

`default_nettype wire

// File: src/aes_round_counter.sv
/*
 * Round counter of the AES control unit
 * First-round and last-round flags
 */

`timescale 1ns/1ps
`default_nettype none

`include "aes_ctrl_params.svh"

module aes_round_counter
(
	input  wire logic            clk,
	input  wire logic            rst_n,
	input  wire logic            round_clear,
	input  wire logic            round_advance,
	output aes_ctrl_pkg::round_t round,
	output logic                 first_round,
	output logic                 last_round
);
	import aes_ctrl_pkg::*;

	// Clear wins over advance
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			round <= '0;
		else if (round_clear)
			round <= '0;
		else if (round_advance)
			round <= round + 1'b1;
	end

	assign first_round = (round == '0);
	// Decryption ends one step past the last round
	assign last_round  = (round == round_t'(`AES_CTRL_NUM_ROUNDS)) ||
	                     (round == round_t'(`AES_CTRL_NUM_ROUNDS + 1));

endmodule

`default_nettype wire

// File: src/aes_ctrl_pkg.sv
/*
 * Types of the AES-128 round control unit
 * Vector typedefs, select and state enums, mode and control structs
 */

`default_nettype none

`include "aes_ctrl_params.svh"

package aes_ctrl_pkg;

	// ====================
	// Vector types
	// ====================

	typedef logic [`AES_CTRL_ROUND_W-1:0] round_t;
	// One bit per column or key word
	typedef logic [`AES_CTRL_NUM_COLS-1:0] lane_mask_t;
	// Key word index
	typedef logic [1:0] key_out_sel_t;

	// ====================
	// Mode encodings
	// ====================

	typedef enum logic [1:0] {
		opm_encryption              = 2'b00,
		opm_key_derivation          = 2'b01,
		opm_decryption              = 2'b10,
		opm_decrypt_with_derivation = 2'b11
	} op_mode_e;

	// 2'b11 is unused
	typedef enum logic [1:0] {
		aes_ecb = 2'b00,
		aes_cbc = 2'b01,
		aes_ctr = 2'b10
	} aes_mode_e;

	// Datapath mux selects
	typedef enum logic [2:0] {
		sbox_col0       = 3'b000,
		sbox_col1       = 3'b001,
		sbox_col2       = 3'b010,
		sbox_col3       = 3'b011,
		sbox_g_function = 3'b100
	} sbox_sel_e;

	typedef enum logic [1:0] {
		rk_column     = 2'b00,
		rk_mixcol_in  = 2'b01,
		rk_mixcol_out = 2'b10
	} rk_sel_e;

	typedef enum logic [1:0] {
		col_shift_rows = 2'b00,
		col_add_rk_out = 2'b01,
		col_input      = 2'b10
	} col_sel_e;

	// Sequencer states, in the order of the original encoding
	typedef enum logic [3:0] {
		st_idle        = 4'd0,
		st_round0_col0 = 4'd1,
		st_round0_col1 = 4'd2,
		st_round0_col2 = 4'd3,
		st_round0_col3 = 4'd4,
		st_round_key   = 4'd5,
		st_round_col0  = 4'd6,
		st_round_col1  = 4'd7,
		st_round_col2  = 4'd8,
		st_round_col3  = 4'd9,
		st_ready       = 4'd10,
		st_gen_key0    = 4'd11,
		st_gen_key1    = 4'd12,
		st_gen_key2    = 4'd13,
		st_gen_key3    = 4'd14,
		st_nop         = 4'd15
	} ctrl_state_e;

	// ====================
	// Structs
	// ====================

	typedef struct packed {
		logic encrypt_decrypt;    // Encrypt direction, key steps included
		logic enc_dec;            // Encrypt direction or CTR
		logic mode_ctr;
		logic mode_cbc;
		logic op_key_derivation;
	} mode_flags_t;

	typedef struct packed {
		sbox_sel_e    sbox_sel;
		rk_sel_e      rk_sel;
		key_out_sel_t key_out_sel;
		col_sel_e     col_sel;
		lane_mask_t   key_en;
		lane_mask_t   col_en;
		logic         bypass_rk;
		logic         bypass_key_en;
		logic         key_sel;            // 0 host key, 1 key out
		logic         iv_cnt_en;
		logic         iv_cnt_sel;         // 0 IV bus, 1 counter
		logic         key_derivation_en;
	} datapath_ctrl_t;

endpackage

`default_nettype wire

// File: src/aes_ctrl_params.svh
/*
 * Sizing macros of the AES-128 round control unit
 * Round count, round counter width, column count
 */

`ifndef AES_CTRL_PARAMS_SVH
`define AES_CTRL_PARAMS_SVH

// ====================
// Round sequencing
// ====================

// Index of the last AES-128 round
`define AES_CTRL_NUM_ROUNDS 10

// Round counter width, holds 0 to 11
`define AES_CTRL_ROUND_W 4

// ====================
// State geometry
// ====================

// Columns of the state, also words of the round key
`define AES_CTRL_NUM_COLS 4

`endif
